//--- riscvPkg.sv
/*
 riscvPkg: ISA-side definitions for the RV32I subset core, covering word
 and register widths, opcodes, funct codes, ALU ops and execute forward selects
*/
`default_nettype none

package riscvPkg;

	// architectural word and register index
	typedef logic [31:0] xlenT;
	typedef logic [4:0] regAddrT;
	typedef logic [2:0] aluOpT;
	typedef logic [1:0] fwdSelT;

	// major opcodes of the supported subset
	localparam logic [6:0] opLui = 7'b0110111;
	localparam logic [6:0] opImm = 7'b0010011;
	localparam logic [6:0] opReg = 7'b0110011;
	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;

	// funct3 / funct7 values
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Xor = 3'b100;
	localparam logic [2:0] f3Or = 3'b110;
	localparam logic [2:0] f3And = 3'b111;
	localparam logic [2:0] f3Word = 3'b010;
	localparam logic [2:0] f3Beq = 3'b000;
	localparam logic [2:0] f3Bne = 3'b001;
	localparam logic [6:0] f7Base = 7'b0000000;
	localparam logic [6:0] f7Sub = 7'b0100000;

	// ALU operations
	localparam aluOpT aluAdd = 3'd0;
	localparam aluOpT aluSub = 3'd1;
	localparam aluOpT aluAnd = 3'd2;
	localparam aluOpT aluOr = 3'd3;
	localparam aluOpT aluXor = 3'd4;
	localparam aluOpT aluSlt = 3'd5;

	// execute operand source
	localparam fwdSelT fwdReg = 2'd0;
	localparam fwdSelT fwdWb = 2'd1;
	localparam fwdSelT fwdMem = 2'd2;

endpackage

`default_nettype wire

//--- memBusPkg.sv
/*
 memBusPkg: memory bus widths, the reset fetch address and the state
 encodings of the four-phase requesters and the bus arbiter
*/
`default_nettype none

package memBusPkg;

	typedef logic [31:0] busAddrT;
	typedef logic [31:0] busDataT;

	// first fetch after reset
	localparam busAddrT resetPc = 32'h0000_0000;

	// requester side of one req/ack handshake
	typedef enum logic [1:0] {portIdle, portReq, portRelease, portDone} portStateT;

	// bus owner
	typedef enum logic [1:0] {arbIdle, arbData, arbFetch, arbDrop} arbStateT;

endpackage

`default_nettype wire

//--- instnDecode.sv
/*
 instnDecode: turns one RV32I subset instruction into control flags,
 register indices and the sign-extended immediate
*/
`timescale 1ns/1ps
`default_nettype none

module instnDecode (
	input riscvPkg::xlenT instn,
	output logic regWrite, memRead, memWrite, aluSrcImm,
	output logic isBranch, branchNe, isJal, isLui,
	output riscvPkg::aluOpT aluOp,
	output riscvPkg::regAddrT rs1, rs2, rd,
	output riscvPkg::xlenT imm
);
	import riscvPkg::*;

	logic [6:0] opcode, funct7;
	logic [2:0] funct3;
	logic useRs1, useRs2, aluF3Ok;
	aluOpT aluF3;
	xlenT immI, immS, immB, immJ, immU;

	assign opcode = instn[6:0];
	assign funct3 = instn[14:12];
	assign funct7 = instn[31:25];

	// immediate formats
	assign immI = {{20{instn[31]}}, instn[31:20]};
	assign immS = {{20{instn[31]}}, instn[31:25], instn[11:7]};
	assign immB = {{19{instn[31]}}, instn[31], instn[7], instn[30:25], instn[11:8], 1'b0};
	assign immJ = {{11{instn[31]}}, instn[31], instn[19:12], instn[20], instn[30:21], 1'b0};
	assign immU = {instn[31:12], 12'b0};

	// funct3 map shared by register and immediate ALU ops
	always_comb begin
		aluF3Ok = 1'b1;
		case (funct3)
			f3AddSub: aluF3 = aluAdd;
			f3Slt: aluF3 = aluSlt;
			f3Xor: aluF3 = aluXor;
			f3Or: aluF3 = aluOr;
			f3And: aluF3 = aluAnd;
			default: begin
				// shifts are not in the subset
				aluF3 = aluAdd;
				aluF3Ok = 1'b0;
			end
		endcase
	end

	always_comb begin
		// defaults give a bubble
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		aluSrcImm = 1'b0;
		isBranch = 1'b0;
		branchNe = 1'b0;
		isJal = 1'b0;
		isLui = 1'b0;
		useRs1 = 1'b0;
		useRs2 = 1'b0;
		aluOp = aluAdd;
		imm = '0;
		case (opcode)
			opLui: begin
				regWrite = 1'b1;
				isLui = 1'b1;
				aluSrcImm = 1'b1;
				imm = immU;
			end
			opImm: begin
				regWrite = aluF3Ok;
				useRs1 = aluF3Ok;
				aluSrcImm = 1'b1;
				aluOp = aluF3;
				imm = immI;
			end
			opReg: begin
				if (aluF3Ok && (funct7 == f7Base || (funct7 == f7Sub && funct3 == f3AddSub))) begin
					regWrite = 1'b1;
					useRs1 = 1'b1;
					useRs2 = 1'b1;
					aluOp = (funct7 == f7Sub) ? aluSub : aluF3;
				end
			end
			opLoad: begin
				// word loads only
				regWrite = funct3 == f3Word;
				memRead = funct3 == f3Word;
				useRs1 = funct3 == f3Word;
				aluSrcImm = 1'b1;
				imm = immI;
			end
			opStore: begin
				memWrite = funct3 == f3Word;
				useRs1 = funct3 == f3Word;
				useRs2 = funct3 == f3Word;
				aluSrcImm = 1'b1;
				imm = immS;
			end
			opBranch: begin
				isBranch = (funct3 == f3Beq) || (funct3 == f3Bne);
				branchNe = funct3 == f3Bne;
				useRs1 = isBranch;
				useRs2 = isBranch;
				imm = immB;
			end
			opJal: begin
				// link is formed in execute from an immediate operand
				regWrite = 1'b1;
				isJal = 1'b1;
				aluSrcImm = 1'b1;
				imm = immJ;
			end
			default: begin
			end
		endcase
	end

	// unused sources read as x0 so they never stall or forward
	assign rs1 = useRs1 ? instn[19:15] : '0;
	assign rs2 = useRs2 ? instn[24:20] : '0;
	assign rd = regWrite ? instn[11:7] : '0;

endmodule

`default_nettype wire

//--- aluExec.sv
/*
 aluExec: execute-stage operand forwarding and the integer ALU
*/
`timescale 1ns/1ps
`default_nettype none

module aluExec (
	input riscvPkg::xlenT rs1Val, rs2Val, imm, resultW, aluOutM,
	input riscvPkg::fwdSelT fwdA, fwdB,
	input logic aluSrcImm,
	input riscvPkg::aluOpT aluOp,
	output riscvPkg::xlenT aluOut, storeData
);
	import riscvPkg::*;

	xlenT opA, opB;

	// register value unless a later stage holds a newer one
	function automatic xlenT pickFwd(fwdSelT sel, xlenT regVal, xlenT wbVal, xlenT memVal);
		case (sel)
			fwdMem: pickFwd = memVal;
			fwdWb: pickFwd = wbVal;
			default: pickFwd = regVal;
		endcase
	endfunction

	assign opA = pickFwd(fwdA, rs1Val, resultW, aluOutM);
	// store data takes the forwarded rs2 too
	assign storeData = pickFwd(fwdB, rs2Val, resultW, aluOutM);
	assign opB = aluSrcImm ? imm : storeData;

	always_comb begin
		case (aluOp)
			aluSub: aluOut = opA - opB;
			aluAnd: aluOut = opA & opB;
			aluOr: aluOut = opA | opB;
			aluXor: aluOut = opA ^ opB;
			aluSlt: aluOut = {31'b0, $signed(opA) < $signed(opB)};
			default: aluOut = opA + opB;
		endcase
	end

endmodule

`default_nettype wire

//--- hazardUnit.sv
/*
 hazardUnit: execute forwarding selects, load-use stall and the
 decode redirect flush
*/
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input riscvPkg::regAddrT rs1D, rs2D,
	input riscvPkg::regAddrT rs1E, rs2E,
	input riscvPkg::regAddrT rdE, rdM, rdW,
	input logic memReadE, regWriteM, regWriteW, branchTakenD,
	output riscvPkg::fwdSelT fwdA, fwdB,
	output logic stallFD, flushD, flushE
);
	import riscvPkg::*;

	logic loadUse;

	// memory stage wins over writeback, x0 never forwards
	function automatic fwdSelT pickSrc(
		regAddrT src,
		regAddrT rdMem,
		regAddrT rdWb,
		logic wrMem,
		logic wrWb
	);
		if (src == '0)
			pickSrc = fwdReg;
		else if (wrMem && rdMem == src)
			pickSrc = fwdMem;
		else if (wrWb && rdWb == src)
			pickSrc = fwdWb;
		else
			pickSrc = fwdReg;
	endfunction

	assign fwdA = pickSrc(rs1E, rdM, rdW, regWriteM, regWriteW);
	assign fwdB = pickSrc(rs2E, rdM, rdW, regWriteM, regWriteW);

	// load in execute feeding a decode source
	assign loadUse = memReadE && rdE != '0 && (rdE == rs1D || rdE == rs2D);

	// hold fetch/decode and bubble execute for one step
	assign stallFD = loadUse;
	assign flushE = loadUse;
	// redirect only once decode is allowed to advance
	assign flushD = branchTakenD && !loadUse;

endmodule

`default_nettype wire

//--- riscvCore.sv
/*
 riscvCore: five-stage RV32I subset pipeline, branches resolved in decode,
 fetch and data ports driven as four-phase handshakes that pace each step
*/
`timescale 1ns/1ps
`default_nettype none

module riscvCore (
	input logic clk,
	input logic rstN,
	output logic fetchReq,
	output memBusPkg::busAddrT fetchAddr,
	input logic fetchAck,
	input memBusPkg::busDataT fetchData,
	output logic dataReq,
	output logic dataWe,
	output memBusPkg::busAddrT dataAddr,
	output memBusPkg::busDataT dataWdata,
	input logic dataAck,
	input memBusPkg::busDataT dataRdata
);
	import riscvPkg::*;
	import memBusPkg::*;

	// handshakes and step strobe
	portStateT fetchState, dataState;
	logic step, memAccessM;
	busDataT fetchWord, loadWord;

	// fetch / decode
	xlenT pcF, pcD, instnD, instnLive;
	logic validD;
	logic regWriteD, memReadD, memWriteD, aluSrcImmD;
	logic isBranchD, branchNeD, isJalD, isLuiD;
	aluOpT aluOpD;
	regAddrT rs1D, rs2D, rdD;
	xlenT immD, rs1FwdD, rs2FwdD, targetD;
	logic branchWaitD, redirectD, holdD, bubbleE;

	// execute / memory / writeback
	logic regWriteE, memReadE, memWriteE, aluSrcImmE;
	aluOpT aluOpE;
	regAddrT rs1E, rs2E, rdE, rdM, rdW;
	xlenT opAE, opBE, immE, aluOutE, storeDataE;
	logic regWriteM, memReadM, memWriteM, regWriteW;
	xlenT aluOutM, storeDataM, resultM, resultW;

	fwdSelT fwdA, fwdB;
	logic stallFD, flushD, flushE;

	xlenT regs [32];

	// one requester handshake
	function automatic portStateT portNext(portStateT cur, logic need, logic ack, logic adv);
		case (cur)
			portIdle: portNext = need ? portReq : portIdle;
			portReq: portNext = ack ? portRelease : portReq;
			portRelease: portNext = ack ? portRelease : portDone;
			default: portNext = adv ? portIdle : portDone;
		endcase
	endfunction

	// newest value of a source seen from decode
	function automatic xlenT readSrc(regAddrT src);
		if (src == '0)
			readSrc = '0;
		else if (regWriteM && rdM == src)
			readSrc = resultM;
		else if (regWriteW && rdW == src)
			readSrc = resultW;
		else
			readSrc = regs[src];
	endfunction

	assign memAccessM = memReadM || memWriteM;
	// both transfers of this step closed
	assign step = fetchState == portDone && (dataState == portDone || !memAccessM);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			fetchState <= portIdle;
			dataState <= portIdle;
		end else begin
			fetchState <= portNext(fetchState, 1'b1, fetchAck, step);
			dataState <= portNext(dataState, memAccessM, dataAck, step);
		end
	end

	// capture words while ack is high
	always_ff @(posedge clk) begin
		if (fetchState == portReq && fetchAck)
			fetchWord <= fetchData;
		if (dataState == portReq && dataAck)
			loadWord <= dataRdata;
	end

	assign fetchReq = fetchState == portReq;
	assign fetchAddr = pcF;
	assign dataReq = dataState == portReq;
	assign dataWe = memWriteM;
	assign dataAddr = aluOutM;
	assign dataWdata = storeDataM;

	// empty decode slot reads as opcode zero
	assign instnLive = validD ? instnD : '0;

	instnDecode uDecode (
		.instn(instnLive),
		.regWrite(regWriteD), .memRead(memReadD), .memWrite(memWriteD),
		.aluSrcImm(aluSrcImmD),
		.isBranch(isBranchD), .branchNe(branchNeD), .isJal(isJalD), .isLui(isLuiD),
		.aluOp(aluOpD),
		.rs1(rs1D), .rs2(rs2D), .rd(rdD),
		.imm(immD)
	);

	always_comb begin
		rs1FwdD = readSrc(rs1D);
		rs2FwdD = readSrc(rs2D);
	end

	// no path from execute into the compare
	assign branchWaitD = isBranchD && regWriteE && rdE != '0 && (rdE == rs1D || rdE == rs2D);
	assign targetD = pcD + immD;
	assign redirectD = isJalD ||
		(isBranchD && !branchWaitD && ((rs1FwdD == rs2FwdD) != branchNeD));
	assign holdD = stallFD || branchWaitD;
	assign bubbleE = flushE || branchWaitD;

	hazardUnit uHazard (
		.rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E),
		.rdE(rdE), .rdM(rdM), .rdW(rdW),
		.memReadE(memReadE), .regWriteM(regWriteM), .regWriteW(regWriteW),
		.branchTakenD(redirectD),
		.fwdA(fwdA), .fwdB(fwdB),
		.stallFD(stallFD), .flushD(flushD), .flushE(flushE)
	);

	aluExec uAlu (
		.rs1Val(opAE), .rs2Val(opBE), .imm(immE),
		.resultW(resultW), .aluOutM(aluOutM),
		.fwdA(fwdA), .fwdB(fwdB),
		.aluSrcImm(aluSrcImmE), .aluOp(aluOpE),
		.aluOut(aluOutE), .storeData(storeDataE)
	);

	// JAL link already left the ALU as pc+4
	assign resultM = memReadM ? loadWord : aluOutM;

	// pc and stage valid/control bits
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcF <= resetPc;
			validD <= 1'b0;
			regWriteE <= 1'b0;
			memReadE <= 1'b0;
			memWriteE <= 1'b0;
			regWriteM <= 1'b0;
			memReadM <= 1'b0;
			memWriteM <= 1'b0;
			regWriteW <= 1'b0;
		end else if (step) begin
			if (!holdD) begin
				pcF <= flushD ? targetD : pcF + 32'd4;
				validD <= !flushD;
			end
			regWriteE <= regWriteD && !bubbleE;
			memReadE <= memReadD && !bubbleE;
			memWriteE <= memWriteD && !bubbleE;
			regWriteM <= regWriteE;
			memReadM <= memReadE;
			memWriteM <= memWriteE;
			regWriteW <= regWriteM;
		end
	end

	// stage payload
	always_ff @(posedge clk) begin
		if (step) begin
			if (!holdD) begin
				pcD <= pcF;
				instnD <= fetchWord;
			end
			// LUI and JAL add their immediate to zero
			opAE <= (isLuiD || isJalD) ? '0 : rs1FwdD;
			opBE <= rs2FwdD;
			immE <= isJalD ? pcD + 32'd4 : immD;
			aluSrcImmE <= aluSrcImmD;
			aluOpE <= aluOpD;
			rs1E <= rs1D;
			rs2E <= rs2D;
			rdE <= rdD;
			aluOutM <= aluOutE;
			storeDataM <= storeDataE;
			rdM <= rdE;
			resultW <= resultM;
			rdW <= rdM;
		end
	end

	// register file, written once per step
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (step && regWriteW && rdW != '0) begin
			regs[rdW] <= resultW;
		end
	end

endmodule

`default_nettype wire

//--- memArbiter.sv
/*
 memArbiter: fixed-priority owner of the shared four-phase memory bus,
 data port ahead of the fetch port
*/
`timescale 1ns/1ps
`default_nettype none

module memArbiter (
	input logic clk,
	input logic rstN,
	input logic fetchReq,
	input memBusPkg::busAddrT fetchAddr,
	output logic fetchAck,
	output memBusPkg::busDataT fetchData,
	input logic dataReq,
	input logic dataWe,
	input memBusPkg::busAddrT dataAddr,
	input memBusPkg::busDataT dataWdata,
	output logic dataAck,
	output memBusPkg::busDataT dataRdata,
	output logic memReq,
	output logic memWe,
	output memBusPkg::busAddrT memAddr,
	output memBusPkg::busDataT memWdata,
	input logic memAck,
	input memBusPkg::busDataT memRdata
);
	import memBusPkg::*;

	arbStateT state, stateNext;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			state <= arbIdle;
		else
			state <= stateNext;
	end

	always_comb begin
		stateNext = state;
		case (state)
			// data first on a tie
			arbIdle: begin
				if (dataReq)
					stateNext = arbData;
				else if (fetchReq)
					stateNext = arbFetch;
			end
			// requester drops req only after ack
			arbData: if (!dataReq) stateNext = arbDrop;
			arbFetch: if (!fetchReq) stateNext = arbDrop;
			// bus closed once the responder lets go
			default: if (!memAck) stateNext = arbIdle;
		endcase
	end

	assign memReq = (state == arbData && dataReq) || (state == arbFetch && fetchReq);
	assign memWe = state == arbData && dataWe;
	assign memAddr = (state == arbData) ? dataAddr : fetchAddr;
	assign memWdata = dataWdata;

	// ack goes back to the granted port only
	assign dataAck = state == arbData && memAck;
	assign fetchAck = state == arbFetch && memAck;
	assign dataRdata = memRdata;
	assign fetchData = memRdata;

endmodule

`default_nettype wire

//--- socTop.sv
/*
 socTop: core plus bus arbiter, one external memory bus
*/
`timescale 1ns/1ps
`default_nettype none

module socTop (
	input logic clk,
	input logic rstN,
	output logic memReq,
	output logic memWe,
	output memBusPkg::busAddrT memAddr,
	output memBusPkg::busDataT memWdata,
	input logic memAck,
	input memBusPkg::busDataT memRdata
);
	import memBusPkg::*;

	// core side ports
	logic fetchReq, fetchAck, dataReq, dataWe, dataAck;
	busAddrT fetchAddr, dataAddr;
	busDataT fetchData, dataWdata, dataRdata;

	riscvCore uCore (
		.clk(clk), .rstN(rstN),
		.fetchReq(fetchReq), .fetchAddr(fetchAddr), .fetchAck(fetchAck), .fetchData(fetchData),
		.dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr), .dataWdata(dataWdata),
		.dataAck(dataAck), .dataRdata(dataRdata)
	);

	memArbiter uArb (
		.clk(clk), .rstN(rstN),
		.fetchReq(fetchReq), .fetchAddr(fetchAddr), .fetchAck(fetchAck), .fetchData(fetchData),
		.dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr), .dataWdata(dataWdata),
		.dataAck(dataAck), .dataRdata(dataRdata),
		.memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
		.memAck(memAck), .memRdata(memRdata)
	);

endmodule

`default_nettype wire

//--- tbSoc.sv
/*
 tbSoc: runs a small RV32I program on socTop against a memory model with
 random ack delay, and checks every store on the bus in program order
*/
`timescale 1ns/1ps
`default_nettype none

module tbSoc;
	import riscvPkg::*;

	localparam int numInstr = 32;
	localparam int numStores = 10;
	// about 40 steps of at most 24 cycles each when both transfers see the longest delays
	localparam int maxCycles = 3000;
	localparam int drainCycles = 200;

	logic clk, rstN, memReq, memWe, memAck;
	logic [31:0] memAddr, memWdata, memRdata;
	logic [31:0] mem [256];
	logic [31:0] progTable [numInstr];
	logic [31:0] expAddr [numStores];
	logic [31:0] expData [numStores];
	logic [31:0] lcgState;
	logic [1:0] delayLeft;
	logic [1:0] holdLeft;
	logic reqPrev, firstSeen;
	int storeIdx, cycleCount, mismatchErrors, otherErrors;

	socTop UUT (
		.clk(clk), .rstN(rstN),
		.memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
		.memAck(memAck), .memRdata(memRdata)
	);

	always #20 clk = ~clk;

	// instruction formats
	function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		encR = {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		encI = {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
		encS = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		encB = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJ(logic [20:0] imm, logic [4:0] rd);
		encJ = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// LCG for the ack delays
	function automatic logic [31:0] nextRand(logic [31:0] s);
		nextRand = s * 32'd1664525 + 32'd1013904223;
	endfunction

	// compare one bus write with the next expected row
	task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
		assert (storeIdx < numStores) else begin
			$display("unexpected extra store at address %h", addr);
			otherErrors++;
		end
		if (storeIdx < numStores) begin
			assert (addr == expAddr[storeIdx]) else begin
				$display("Mismatch memAddr: got %h expected %h", addr, expAddr[storeIdx]);
				mismatchErrors++;
			end
			assert (data == expData[storeIdx]) else begin
				$display("Mismatch memWdata: got %h expected %h", data, expData[storeIdx]);
				mismatchErrors++;
			end
			storeIdx++;
		end
	endtask

	// responder answering one transaction per req
	always @(posedge clk) begin
		if (!rstN) begin
			memAck <= 1'b0;
			delayLeft <= 2'd0;
			holdLeft <= 2'd0;
		end else if (!memAck && memReq) begin
			if (delayLeft == 2'd0) begin
				memAck <= 1'b1;
				memRdata <= mem[memAddr[9:2]];
				if (memWe) begin
					mem[memAddr[9:2]] = memWdata;
					checkStore(memAddr, memWdata);
				end
			end else begin
				delayLeft <= delayLeft - 2'd1;
			end
		end else if (memAck && !memReq) begin
			// ack may linger after req falls
			if (holdLeft == 2'd0) begin
				memAck <= 1'b0;
				lcgState <= nextRand(lcgState);
				delayLeft <= lcgState[17:16];
				holdLeft <= lcgState[21:20];
			end else begin
				holdLeft <= holdLeft - 2'd1;
			end
		end
	end

	// bus protocol and reset checks every cycle
	always @(posedge clk) begin
		cycleCount++;
		if (!rstN) begin
			assert (!memReq) else begin
				$display("memReq was high during reset");
				otherErrors++;
			end
		end else begin
			assert (!(memReq && !reqPrev && memAck)) else begin
				$display("memReq rose while memAck was still high");
				otherErrors++;
			end
			if (memReq && !firstSeen) begin
				firstSeen = 1'b1;
				assert (!memWe && memAddr == 32'h0) else begin
					$display("first request after reset was not a read at address zero");
					otherErrors++;
				end
			end
		end
		reqPrev <= memReq;
	end

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		memAck = 1'b0;
		memRdata = '0;
		lcgState = 32'h9ee8;
		delayLeft = 2'd0;
		holdLeft = 2'd0;
		reqPrev = 1'b0;
		firstSeen = 1'b0;
		storeIdx = 0;
		cycleCount = 0;
		mismatchErrors = 0;
		otherErrors = 0;

		progTable[0] = encI(12'd5, 5'd0, 3'b000, 5'd1, opImm); // addi x1,x0,5
		progTable[1] = encI(12'd7, 5'd1, 3'b000, 5'd2, opImm); // addi x2,x1,7
		progTable[2] = encR(7'h00, 5'd2, 5'd1, 3'b000, 5'd3); // add x3,x1,x2
		progTable[3] = encR(7'h20, 5'd1, 5'd3, 3'b000, 5'd4); // sub x4,x3,x1
		progTable[4] = encR(7'h00, 5'd3, 5'd4, 3'b100, 5'd5); // xor x5,x4,x3
		progTable[5] = encR(7'h00, 5'd2, 5'd1, 3'b010, 5'd6); // slt x6,x1,x2
		progTable[6] = encS(12'h100, 5'd2, 5'd0); // sw x2,0x100(x0)
		progTable[7] = encS(12'h104, 5'd3, 5'd0); // sw x3,0x104(x0)
		progTable[8] = encS(12'h108, 5'd4, 5'd0); // sw x4,0x108(x0)
		progTable[9] = encS(12'h10c, 5'd5, 5'd0); // sw x5,0x10c(x0)
		progTable[10] = encS(12'h110, 5'd6, 5'd0); // sw x6,0x110(x0)
		progTable[11] = encI(12'h200, 5'd0, 3'b010, 5'd7, opLoad); // lw x7,0x200(x0)
		progTable[12] = encR(7'h00, 5'd1, 5'd7, 3'b000, 5'd8); // add x8,x7,x1
		progTable[13] = encS(12'h114, 5'd8, 5'd0); // sw x8,0x114(x0)
		progTable[14] = encB(13'd8, 5'd1, 5'd1, 3'b000); // beq x1,x1,+8
		progTable[15] = encS(12'h1f0, 5'd1, 5'd0); // sw x1,0x1f0(x0) is skipped
		progTable[16] = encI(12'haa, 5'd0, 3'b000, 5'd9, opImm); // addi x9,x0,0xaa
		progTable[17] = encB(13'd8, 5'd0, 5'd9, 3'b001); // bne x9,x0,+8
		progTable[18] = encS(12'h1f0, 5'd1, 5'd0); // sw x1,0x1f0(x0) is skipped
		progTable[19] = encB(13'd8, 5'd1, 5'd1, 3'b001); // bne x1,x1,+8 not taken
		progTable[20] = encI(12'h55, 5'd0, 3'b000, 5'd10, opImm); // addi x10,x0,0x55
		progTable[21] = encS(12'h118, 5'd9, 5'd0); // sw x9,0x118(x0)
		progTable[22] = encS(12'h11c, 5'd10, 5'd0); // sw x10,0x11c(x0)
		progTable[23] = encJ(21'd8, 5'd11); // jal x11,+8
		progTable[24] = encS(12'h1f0, 5'd1, 5'd0); // sw x1,0x1f0(x0) is skipped
		progTable[25] = encS(12'h120, 5'd11, 5'd0); // sw x11,0x120(x0)
		progTable[26] = {20'habcde, 5'd12, opLui}; // lui x12,0xabcde
		progTable[27] = encS(12'h124, 5'd12, 5'd0); // sw x12,0x124(x0)
		progTable[28] = encJ(21'd0, 5'd0); // jal x0,0 spins here
		progTable[29] = encJ(21'd0, 5'd0);
		progTable[30] = encJ(21'd0, 5'd0);
		progTable[31] = encJ(21'd0, 5'd0);

		// expected stores from RV32I semantics
		expAddr[0] = 32'h100;
		expData[0] = 32'd5 + 32'd7;
		expAddr[1] = 32'h104;
		expData[1] = 32'd5 + 32'd12;
		expAddr[2] = 32'h108;
		expData[2] = 32'd17 - 32'd5;
		expAddr[3] = 32'h10c;
		expData[3] = 32'd12 ^ 32'd17;
		expAddr[4] = 32'h110;
		expData[4] = 32'd1;
		expAddr[5] = 32'h114;
		expData[5] = 32'h1234 + 32'd5;
		expAddr[6] = 32'h118;
		expData[6] = 32'haa;
		expAddr[7] = 32'h11c;
		expData[7] = 32'h55;
		expAddr[8] = 32'h120;
		expData[8] = 32'h5c + 32'd4;
		expAddr[9] = 32'h124;
		expData[9] = 32'habcde000;

		// fill tied to the byte address before the program and load data go in
		for (int i = 0; i < 256; i++)
			mem[i] = 32'ha5a50000 | (i * 4);
		for (int i = 0; i < numInstr; i++)
			mem[i] = progTable[i];
		mem[32'h200 >> 2] = 32'h1234;

		repeat (10) @(posedge clk);
		rstN <= 1'b1;

		while (storeIdx < numStores && cycleCount < maxCycles)
			@(posedge clk);
		// keep running to catch stray or duplicate stores
		if (cycleCount < maxCycles)
			repeat (drainCycles) @(posedge clk);
		else begin
			$display("timeout: run hit %0d cycles before all stores were seen", maxCycles);
			otherErrors++;
		end
		if (storeIdx < numStores) begin
			$display("missing stores: saw %0d of %0d", storeIdx, numStores);
			otherErrors++;
		end

		$display("errors: %0d mismatches, %0d other failures", mismatchErrors, otherErrors);
		if (mismatchErrors == 0 && otherErrors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
riscvPkg.sv
memBusPkg.sv
instnDecode.sv
aluExec.sv
hazardUnit.sv
riscvCore.sv
memArbiter.sv
socTop.sv
tbSoc.sv

//--- run.sh
#!/bin/sh
# build and run the SoC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tbSoc -o simTbSoc
./obj_dir/simTbSoc > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
	exit 0
else
	exit 1
fi
